//--- spi_frame_pkg.sv
// SPI frame format
// Field widths of the serial frame and the command frozen at frame start
package spi_frame_pkg;

    // Peripheral register address bits
    localparam int addr_width = 10;
    // Command and read buffer word size
    localparam int word_width = 32;
    // Length field, 1 to 255 data bits
    localparam int len_width = 8;
    // Direction bit followed by the address
    localparam int header_bits = 1 + addr_width;

    // Command levels as seen in the start cycle of a frame
    typedef struct packed {
        // 1 for write, 0 for read
        logic                  wnr;
        logic [addr_width-1:0] address;
        logic [len_width-1:0]  data_len;
    } spi_cmd_t;

endpackage

//--- spi_ctrl_pkg.sv
// SPI controller internals
// Sequencer state and the strobes shared by the timer and the shifters
package spi_ctrl_pkg;

    // Default buffer depth, power of two
    localparam int fifo_depth = 16;

    // Bit position within a buffer word
    localparam int bit_index_width = $clog2(spi_frame_pkg::word_width);

    // Header bit counter and its value on the last header bit
    localparam int header_cnt_width = $clog2(spi_frame_pkg::header_bits);
    localparam logic [header_cnt_width-1:0] header_cnt_last =
        header_cnt_width'(spi_frame_pkg::header_bits - 1);

    // Frame FSM
    typedef enum logic [1:0] {
        idle         = 2'd0,
        header       = 2'd1,
        send_data    = 2'd2,
        receive_data = 2'd3
    } seq_state_t;

    // Sequencer to timer
    typedef struct packed {
        // Clear all counters for a new frame
        logic start;
        logic run_header;
        logic run_data;
    } timer_ctl_t;

    // Timer to sequencer and shifters
    typedef struct packed {
        logic                       header_last;
        logic                       data_last;
        logic                       word_last;
        logic [bit_index_width-1:0] bit_index;
    } timer_stat_t;

    // Sequencer to shifters
    typedef struct packed {
        logic load_header;
        // Also pops the command FIFO
        logic load_word;
        logic shift;
        logic capture;
        // Push the partial read word
        logic flush;
    } shift_ctl_t;

endpackage

//--- spi_word_fifo.sv
// Synchronous word FIFO
// Circular buffer with a show-ahead head word, used for command and read data
module spi_word_fifo #(
    parameter int depth = spi_ctrl_pkg::fifo_depth
) (
    input  logic                                 axi_clk,
    input  logic                                 reset_b,
    input  logic                                 wr_en,
    input  logic [spi_frame_pkg::word_width-1:0] din,
    input  logic                                 rd_en,
    output logic [spi_frame_pkg::word_width-1:0] dout,
    output logic                                 full,
    output logic                                 empty
);

    // Storage
    logic [spi_frame_pkg::word_width-1:0] mem [depth];

    // Pointers wrap on their own for a power-of-two depth
    logic [$clog2(depth)-1:0] wr_ptr;
    logic [$clog2(depth)-1:0] rd_ptr;
    // Words held, 0 to depth
    logic [$clog2(depth):0]   count;

    // Pointer and fill tracking
    always_ff @(posedge axi_clk or negedge reset_b) begin
        if (!reset_b) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Push lands in the same cycle as the strobe
    always_ff @(posedge axi_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    // Head word is always visible
    assign dout  = mem[rd_ptr];
    assign full  = (count == ($clog2(depth) + 1)'(depth));
    assign empty = (count == '0);

    // No back-pressure upstream, so overflow or underflow is a software error
    assert property (@(posedge axi_clk) disable iff (!reset_b) wr_en |-> !full);
    assert property (@(posedge axi_clk) disable iff (!reset_b) rd_en |-> !empty);

endmodule

//--- spi_bit_timer.sv
// SPI bit timer
// Counts header bits, data bits and the bit position within a word
module spi_bit_timer (
    input  logic                                axi_clk,
    input  logic                                reset_b,
    input  spi_ctrl_pkg::timer_ctl_t            ctl,
    input  logic [spi_frame_pkg::len_width-1:0] data_len,
    output spi_ctrl_pkg::timer_stat_t           stat
);

    // Header bits already sent
    logic [spi_ctrl_pkg::header_cnt_width-1:0] header_cnt;
    // Data bits already moved
    logic [spi_frame_pkg::len_width-1:0]       data_cnt;
    // Current bit of the word, 31 down to 0
    logic [spi_ctrl_pkg::bit_index_width-1:0]  bit_pos;

    always_ff @(posedge axi_clk or negedge reset_b) begin
        if (!reset_b) begin
            header_cnt <= '0;
            data_cnt   <= '0;
            bit_pos    <= '1;
        end else if (ctl.start) begin
            // New frame starts at the top of the first word
            header_cnt <= '0;
            data_cnt   <= '0;
            bit_pos    <= '1;
        end else begin
            if (ctl.run_header) begin
                header_cnt <= header_cnt + 1'b1;
            end
            if (ctl.run_data) begin
                data_cnt <= data_cnt + 1'b1;
                // Wraps from 0 back to 31 for the next word
                bit_pos  <= bit_pos - 1'b1;
            end
        end
    end

    // Last flags only count while their phase runs
    assign stat.header_last = ctl.run_header && (header_cnt == spi_ctrl_pkg::header_cnt_last);
    assign stat.data_last   = ctl.run_data && (data_cnt == data_len - 1'b1);
    assign stat.word_last   = ctl.run_data && (bit_pos == '0);
    assign stat.bit_index   = bit_pos;

endmodule

//--- spi_sequencer.sv
// SPI frame sequencer
// Captures the command, walks header and data phases, handles abort and done
module spi_sequencer (
    input  logic                                 axi_clk,
    input  logic                                 reset_b,
    input  logic                                 wnr,
    input  logic [spi_frame_pkg::addr_width-1:0] spi_address,
    input  logic [spi_frame_pkg::len_width-1:0]  spi_data_len,
    input  spi_ctrl_pkg::timer_stat_t            stat,
    output spi_frame_pkg::spi_cmd_t              cmd,
    output spi_ctrl_pkg::timer_ctl_t             tctl,
    output spi_ctrl_pkg::shift_ctl_t             sctl,
    output logic                                 cs_b,
    output logic                                 done
);

    spi_ctrl_pkg::seq_state_t state;
    spi_ctrl_pkg::seq_state_t next_state;

    // Live software levels and the copy held during a frame
    spi_frame_pkg::spi_cmd_t cmd_live;
    spi_frame_pkg::spi_cmd_t cmd_q;

    // Zero length while busy
    logic abort;
    // Last data bit of a completed frame
    logic frame_end;

    assign cmd_live = '{wnr: wnr, address: spi_address, data_len: spi_data_len};
    assign abort    = (state != spi_ctrl_pkg::idle) && (spi_data_len == '0);

    // Shifters load the header in the start cycle before the copy exists
    assign cmd = (state == spi_ctrl_pkg::idle) ? cmd_live : cmd_q;

    always_comb begin
        next_state = state;
        tctl       = '0;
        sctl       = '0;
        frame_end  = 1'b0;
        if (abort) begin
            // All strobes stay low so partial words are dropped
            next_state = spi_ctrl_pkg::idle;
        end else begin
            case (state)
                spi_ctrl_pkg::idle: begin
                    if (spi_data_len != '0) begin
                        next_state       = spi_ctrl_pkg::header;
                        tctl.start       = 1'b1;
                        sctl.load_header = 1'b1;
                    end
                end
                spi_ctrl_pkg::header: begin
                    tctl.run_header = 1'b1;
                    sctl.shift      = 1'b1;
                    if (stat.header_last) begin
                        // First write word is popped just before its first bit
                        sctl.load_word = cmd_q.wnr;
                        if (cmd_q.wnr) begin
                            next_state = spi_ctrl_pkg::send_data;
                        end else begin
                            next_state = spi_ctrl_pkg::receive_data;
                        end
                    end
                end
                spi_ctrl_pkg::send_data: begin
                    tctl.run_data  = 1'b1;
                    sctl.shift     = 1'b1;
                    // Next word only if bits remain after this one
                    sctl.load_word = stat.word_last && !stat.data_last;
                    if (stat.data_last) begin
                        next_state = spi_ctrl_pkg::idle;
                        frame_end  = 1'b1;
                    end
                end
                spi_ctrl_pkg::receive_data: begin
                    tctl.run_data = 1'b1;
                    sctl.capture  = 1'b1;
                    sctl.flush    = stat.data_last;
                    if (stat.data_last) begin
                        next_state = spi_ctrl_pkg::idle;
                        frame_end  = 1'b1;
                    end
                end
                default: next_state = spi_ctrl_pkg::idle;
            endcase
        end
    end

    // cs_b and done come straight from flops
    always_ff @(posedge axi_clk or negedge reset_b) begin
        if (!reset_b) begin
            state <= spi_ctrl_pkg::idle;
            cs_b  <= 1'b1;
            done  <= 1'b0;
        end else begin
            state <= next_state;
            cs_b  <= (next_state == spi_ctrl_pkg::idle);
            done  <= frame_end;
        end
    end

    // Frame copy taken in the start cycle
    always_ff @(posedge axi_clk) begin
        if (tctl.start) begin
            cmd_q <= cmd_live;
        end
    end

    // done is one cycle wide
    assert property (@(posedge axi_clk) disable iff (!reset_b) done |=> !done);
    // Chip select releases only at done or after a zero length
    assert property (@(posedge axi_clk) disable iff (!reset_b)
        $rose(cs_b) |-> done || $past(spi_data_len == '0));
    // done only when chip select has just released
    assert property (@(posedge axi_clk) disable iff (!reset_b) done |-> $rose(cs_b));

endmodule

//--- spi_tx_shifter.sv
// SPI transmit shifter
// Sends direction, address and command words on pico, MSB first
module spi_tx_shifter (
    input  logic                                 axi_clk,
    input  logic                                 reset_b,
    input  spi_frame_pkg::spi_cmd_t              cmd,
    input  spi_ctrl_pkg::shift_ctl_t             sctl,
    input  spi_ctrl_pkg::timer_stat_t            stat,
    input  logic [spi_frame_pkg::word_width-1:0] cmd_dout,
    output logic                                 cmd_rd_en,
    output logic                                 pico
);

    // Outgoing bits, top bit on the wire
    logic [spi_frame_pkg::word_width-1:0] tx_q;

    always_ff @(posedge axi_clk or negedge reset_b) begin
        if (!reset_b) begin
            tx_q <= '0;
        end else if (sctl.load_header) begin
            // Header sits in the top 11 bits, zeros below
            tx_q <= {cmd.wnr, cmd.address,
                     {(spi_frame_pkg::word_width - spi_frame_pkg::header_bits){1'b0}}};
        end else if (sctl.load_word) begin
            tx_q <= cmd_dout;
        end else if (sctl.shift && !stat.data_last) begin
            tx_q <= {tx_q[spi_frame_pkg::word_width-2:0], 1'b0};
        end else begin
            // Last bit sent or no frame, so pico drops low
            tx_q <= '0;
        end
    end

    // Loading a word pops it from the command FIFO
    assign cmd_rd_en = sctl.load_word;
    assign pico      = tx_q[spi_frame_pkg::word_width-1];

    // Read frames never consume command words
    assert property (@(posedge axi_clk) disable iff (!reset_b) sctl.load_word |-> cmd.wnr);

endmodule

//--- spi_rx_shifter.sv
// SPI receive shifter
// Packs poci bits into words from bit 31 down and pushes them to the read FIFO
module spi_rx_shifter (
    input  logic                                 axi_clk,
    input  logic                                 reset_b,
    input  spi_ctrl_pkg::shift_ctl_t             sctl,
    input  spi_ctrl_pkg::timer_stat_t            stat,
    input  logic                                 poci,
    output logic                                 rd_wr_en,
    output logic [spi_frame_pkg::word_width-1:0] rd_din
);

    // Word complete, push in the following cycle
    logic                                 push_q;
    logic [spi_frame_pkg::word_width-1:0] word_next;

    always_comb begin
        // Start clean after a push, and drop anything outside a capture
        if (sctl.capture && !push_q) begin
            word_next = rd_din;
        end else begin
            word_next = '0;
        end
        if (sctl.capture) begin
            word_next[stat.bit_index] = poci;
        end
    end

    // Assembly register doubles as the FIFO write data
    always_ff @(posedge axi_clk) begin
        rd_din <= word_next;
    end

    always_ff @(posedge axi_clk or negedge reset_b) begin
        if (!reset_b) begin
            push_q <= 1'b0;
        end else begin
            // Full word, or the last bit of the frame
            push_q <= sctl.capture && (stat.word_last || sctl.flush);
        end
    end

    assign rd_wr_en = push_q;

endmodule

//--- spi_master_top.sv
// SPI command path top level
// Command and read FIFOs around the frame sequencer, bit timer and shifters
module spi_master_top (
    input  logic                                 axi_clk,
    input  logic                                 reset_b,
    // Software levels
    input  logic                                 wnr,
    input  logic [spi_frame_pkg::addr_width-1:0] spi_address,
    input  logic [spi_frame_pkg::len_width-1:0]  spi_data_len,
    // Write data in
    input  logic                                 cmd_wr_en,
    input  logic [spi_frame_pkg::word_width-1:0] cmd_din,
    output logic                                 cmd_full,
    // Read data out
    input  logic                                 rd_rd_en,
    output logic [spi_frame_pkg::word_width-1:0] rd_dout,
    output logic                                 rd_empty,
    // SPI pins
    output logic                                 pico,
    output logic                                 cs_b,
    output logic                                 spi_clk,
    input  logic                                 poci,
    output logic                                 done
);

    spi_frame_pkg::spi_cmd_t              cmd;
    spi_ctrl_pkg::timer_ctl_t             tctl;
    spi_ctrl_pkg::timer_stat_t            stat;
    spi_ctrl_pkg::shift_ctl_t             sctl;
    logic                                 cmd_rd_en;
    logic [spi_frame_pkg::word_width-1:0] cmd_dout;
    logic                                 rd_wr_en;
    logic [spi_frame_pkg::word_width-1:0] rd_din;

    // Serial clock runs at the bus clock
    assign spi_clk = axi_clk;

    // Underflow is caught inside the FIFO
    spi_word_fifo #(.depth(spi_ctrl_pkg::fifo_depth)) cmd_fifo (
        .axi_clk(axi_clk), .reset_b(reset_b),
        .wr_en(cmd_wr_en), .din(cmd_din),
        .rd_en(cmd_rd_en), .dout(cmd_dout),
        .full(cmd_full), .empty()
    );

    // Overflow is caught inside the FIFO
    spi_word_fifo #(.depth(spi_ctrl_pkg::fifo_depth)) read_fifo (
        .axi_clk(axi_clk), .reset_b(reset_b),
        .wr_en(rd_wr_en), .din(rd_din),
        .rd_en(rd_rd_en), .dout(rd_dout),
        .full(), .empty(rd_empty)
    );

    spi_sequencer u_sequencer (
        .axi_clk(axi_clk), .reset_b(reset_b),
        .wnr(wnr), .spi_address(spi_address), .spi_data_len(spi_data_len),
        .stat(stat), .cmd(cmd), .tctl(tctl), .sctl(sctl),
        .cs_b(cs_b), .done(done)
    );

    // Length comes from the captured command, not the live level
    spi_bit_timer u_bit_timer (
        .axi_clk(axi_clk), .reset_b(reset_b),
        .ctl(tctl), .data_len(cmd.data_len), .stat(stat)
    );

    spi_tx_shifter u_tx_shifter (
        .axi_clk(axi_clk), .reset_b(reset_b),
        .cmd(cmd), .sctl(sctl), .stat(stat),
        .cmd_dout(cmd_dout), .cmd_rd_en(cmd_rd_en), .pico(pico)
    );

    spi_rx_shifter u_rx_shifter (
        .axi_clk(axi_clk), .reset_b(reset_b),
        .sctl(sctl), .stat(stat), .poci(poci),
        .rd_wr_en(rd_wr_en), .rd_din(rd_din)
    );

endmodule

//--- spi_periph_model.sv
// SPI peripheral model
// Records every bit seen on pico while selected and returns read bits on poci
module spi_periph_model (
    input  logic spi_clk,
    input  logic cs_b,
    input  logic pico,
    output logic poci
);
    timeunit 1ns;
    timeprecision 100ps;

    // Header plus the longest data phase
    localparam int max_bits = spi_frame_pkg::header_bits + 255;

    // Bits of the latest frame, direction bit first
    logic frame_bits [max_bits];
    int   bit_count;
    // Selected at the last rising edge
    logic active;
    // Data bits returned in read frames, loaded by the testbench
    logic read_bits [256];

    initial begin
        poci      = 1'b0;
        bit_count = 0;
        active    = 1'b0;
    end

    // pico sampled on the rising edge, count restarts with each new frame
    always @(posedge spi_clk) begin
        if (!cs_b) begin
            if (!active) begin
                active    = 1'b1;
                bit_count = 0;
            end
            if (bit_count < max_bits) begin
                frame_bits[bit_count] = pico;
            end
            bit_count = bit_count + 1;
        end else begin
            active = 1'b0;
        end
    end

    // poci changes after the falling edge, data phase only
    always @(negedge spi_clk) begin
        if (!cs_b && active && bit_count >= spi_frame_pkg::header_bits &&
            bit_count < spi_frame_pkg::header_bits + 256) begin
            poci <= read_bits[bit_count - spi_frame_pkg::header_bits];
        end else begin
            poci <= 1'b0;
        end
    end

endmodule

//--- tb_spi_master_top.sv
// Testbench for the SPI command path
// Runs a table of write, read and abort frames against the peripheral model
module tb_spi_master_top;
    timeunit 1ns;
    timeprecision 100ps;

    // One table row with stimulus and the expected chip select window
    typedef struct packed {
        spi_frame_pkg::spi_cmd_t cmd;
        // Cycle in which the length is cleared or 0 for none
        int                      abort_at;
        int                      cs_low_cycles;
        logic                    expect_done;
    } frame_entry_t;

    localparam int num_frames = 11;
    // Longest wait for any single event
    localparam int poll_limit = 16;

    logic                                 axi_clk;
    logic                                 reset_b;
    logic                                 wnr;
    logic [spi_frame_pkg::addr_width-1:0] spi_address;
    logic [spi_frame_pkg::len_width-1:0]  spi_data_len;
    logic                                 cmd_wr_en;
    logic [spi_frame_pkg::word_width-1:0] cmd_din;
    logic                                 cmd_full;
    logic                                 rd_rd_en;
    logic [spi_frame_pkg::word_width-1:0] rd_dout;
    logic                                 rd_empty;
    logic                                 pico;
    logic                                 cs_b;
    logic                                 spi_clk;
    logic                                 poci;
    logic                                 done;

    frame_entry_t frames [num_frames];
    // Words pushed for the current write frame
    logic [31:0]  tx_words [8];
    int           error_count;

    spi_master_top uut (.*);

    spi_periph_model periph (
        .spi_clk(spi_clk),
        .cs_b(cs_b),
        .pico(pico),
        .poci(poci)
    );

    // 8 ns clock
    initial begin
        axi_clk = 1'b0;
        forever #4 axi_clk = ~axi_clk;
    end

    // Just past the next rising edge, where inputs change and outputs are read
    task automatic step();
        @(posedge axi_clk);
        #1;
    endtask

    task automatic report_value(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        error_count++;
        $display("error: time %0d ns, %s = 0x%0h, expected 0x%0h",
                 $time, name, actual, expected);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_text(input string what);
        error_count++;
        $display("error: time %0d ns, %s", $time, what);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        assert (actual === expected) else report_value(name, 32'(actual), 32'(expected));
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else report_value(name, actual, expected);
    endtask

    function automatic frame_entry_t make_entry(input logic is_write,
                                                input logic [9:0] address,
                                                input logic [7:0] len, input int abort_at,
                                                input int cs_low, input logic expect_done);
        frame_entry_t e;
        e.cmd.wnr      = is_write;
        e.cmd.address  = address;
        e.cmd.data_len = len;
        e.abort_at     = abort_at;
        e.cs_low_cycles = cs_low;
        e.expect_done  = expect_done;
        return e;
    endfunction

    // Word k is popped in cycle 11 + 32k and an abort stops later pops
    function automatic int words_used(input int len, input int abort_at);
        int n;
        n = 0;
        for (int k = 0; k < (len + 31) / 32; k++) begin
            if (abort_at == 0 || spi_frame_pkg::header_bits + 32 * k < abort_at) begin
                n++;
            end
        end
        return n;
    endfunction

    // First received bit at bit 31 and zeros past the end of the frame
    function automatic logic [31:0] expected_read_word(input int k, input int len);
        logic [31:0] w;
        w = '0;
        for (int j = 0; j < 32; j++) begin
            if (32 * k + j < len) begin
                w[31 - j] = periph.read_bits[32 * k + j];
            end
        end
        return w;
    endfunction

    task automatic push_word(input logic [31:0] word);
        check_flag("cmd_full", cmd_full, 1'b0);
        cmd_wr_en = 1'b1;
        cmd_din   = word;
        step();
        cmd_wr_en = 1'b0;
    endtask

    task automatic pop_read_word(input logic [31:0] expected);
        int polls;
        polls = 0;
        while (rd_empty && polls < poll_limit) begin
            step();
            polls++;
        end
        assert (!rd_empty) else report_text("timed out waiting for a read word");
        check_value("rd_dout", rd_dout, expected);
        rd_rd_en = 1'b1;
        step();
        rd_rd_en = 1'b0;
    endtask

    task automatic run_frame(input frame_entry_t e);
        int          len;
        int          cyc;
        int          data_bits;
        logic [31:0] r;
        logic        seen_done;
        len = int'(e.cmd.data_len);
        if (e.cmd.wnr) begin
            // Only the words the frame pops, so an abort leaves none behind
            for (int k = 0; k < words_used(len, e.abort_at); k++) begin
                tx_words[k] = $urandom;
                push_word(tx_words[k]);
            end
        end else begin
            for (int b = 0; b < len; b++) begin
                r = $urandom;
                periph.read_bits[b] = r[0];
            end
        end
        // Cycle 0 with the levels captured at the next edge
        wnr          = e.cmd.wnr;
        spi_address  = e.cmd.address;
        spi_data_len = e.cmd.data_len;
        cyc          = 0;
        seen_done    = 1'b0;
        while (!seen_done && cyc < e.cs_low_cycles + poll_limit) begin
            step();
            cyc++;
            check_flag("spi_clk", spi_clk, axi_clk);
            check_flag("cs_b", cs_b, cyc > e.cs_low_cycles);
            check_flag("done", done, e.expect_done && cyc == e.cs_low_cycles + 1);
            // Length cleared after done, or mid-frame for an abort
            if (done || cyc == e.abort_at) begin
                spi_data_len = '0;
            end
            seen_done = done;
        end
        assert (seen_done || !e.expect_done) else report_text("timed out waiting for done");
        // done lasts one cycle and no new frame starts
        step();
        check_flag("done", done, 1'b0);
        check_flag("cs_b", cs_b, 1'b1);

        // Model saw one bit per selected cycle
        check_value("model bit count", periph.bit_count, e.cs_low_cycles);
        check_flag("model direction bit", periph.frame_bits[0], e.cmd.wnr);
        for (int j = 0; j < spi_frame_pkg::addr_width; j++) begin
            check_flag($sformatf("model address bit %0d", 9 - j), periph.frame_bits[1 + j],
                       e.cmd.address[9 - j]);
        end
        data_bits = e.cs_low_cycles - spi_frame_pkg::header_bits;
        if (e.cmd.wnr) begin
            // MSB of each word first
            for (int i = 0; i < data_bits; i++) begin
                check_flag($sformatf("model data bit %0d", i),
                           periph.frame_bits[spi_frame_pkg::header_bits + i],
                           tx_words[i / 32][31 - i % 32]);
            end
        end else if (e.expect_done) begin
            for (int k = 0; k < (len + 31) / 32; k++) begin
                pop_read_word(expected_read_word(k, len));
            end
        end
        // All words taken, and an aborted read leaves no partial word
        check_flag("rd_empty", rd_empty, 1'b1);
    endtask

    initial begin
        error_count = 0;
        void'($urandom(32'h9d756c75));
        reset_b      = 1'b0;
        wnr          = 1'b0;
        spi_address  = '0;
        spi_data_len = '0;
        cmd_wr_en    = 1'b0;
        cmd_din      = '0;
        rd_rd_en     = 1'b0;

        // Direction, address, length, abort cycle, cs_b low cycles, done expected
        frames[0]  = make_entry(1'b1, 10'h3a5, 8'd1, 0, 12, 1'b1);
        frames[1]  = make_entry(1'b1, 10'h0c3, 8'd32, 0, 43, 1'b1);
        frames[2]  = make_entry(1'b1, 10'h2f0, 8'd33, 0, 44, 1'b1);
        frames[3]  = make_entry(1'b1, 10'h15a, 8'd70, 0, 81, 1'b1);
        frames[4]  = make_entry(1'b0, 10'h001, 8'd5, 0, 16, 1'b1);
        frames[5]  = make_entry(1'b0, 10'h3ff, 8'd32, 0, 43, 1'b1);
        frames[6]  = make_entry(1'b0, 10'h200, 8'd40, 0, 51, 1'b1);
        // Aborts before the second command word and before any full read word
        frames[7]  = make_entry(1'b1, 10'h0aa, 8'd70, 30, 30, 1'b0);
        frames[8]  = make_entry(1'b0, 10'h155, 8'd40, 30, 30, 1'b0);
        frames[9]  = make_entry(1'b1, 10'h2c7, 8'd33, 0, 44, 1'b1);
        frames[10] = make_entry(1'b0, 10'h39e, 8'd40, 0, 51, 1'b1);

        repeat (16) @(posedge axi_clk);
        #1;
        reset_b = 1'b1;

        // Idle state out of reset
        check_flag("cs_b", cs_b, 1'b1);
        check_flag("done", done, 1'b0);
        check_flag("pico", pico, 1'b0);
        check_flag("rd_empty", rd_empty, 1'b1);
        check_flag("cmd_full", cmd_full, 1'b0);

        for (int i = 0; i < num_frames; i++) begin
            run_frame(frames[i]);
        end

        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- spi_master_top.f
spi_frame_pkg.sv
spi_ctrl_pkg.sv
spi_word_fifo.sv
spi_bit_timer.sv
spi_sequencer.sv
spi_tx_shifter.sv
spi_rx_shifter.sv
spi_master_top.sv
spi_periph_model.sv
tb_spi_master_top.sv

//--- Makefile
# Verilator build and run of the SPI command path testbench
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_spi_master_top
FILELIST = spi_master_top.f

OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Pass or fail is taken from the log, not from the exit status
run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
